// ==== hdl/vcache_pkg.sv ====
//--------------------------------------------------
// shared types for the vcache tile array
// data word, bank address, row, tag, arbiter state
//--------------------------------------------------

package vcache_pkg;

  // field widths
  localparam int data_width_lp = 32;
  localparam int addr_width_lp = 8;
  localparam int row_width_lp  = 4;
  localparam int tag_width_lp  = 6;

  // one data word
  typedef logic [data_width_lp-1:0] data_t;

  // word address inside a bank, at most 256 words
  typedef logic [addr_width_lp-1:0] addr_t;

  // row coordinate carried down each column
  typedef logic [row_width_lp-1:0] row_t;

  // request id, echoed back in the response
  typedef logic [tag_width_lp-1:0] tag_t;

  // which response source won the last grant
  typedef enum logic {
    GRANT_LOCAL = 1'b0,
    GRANT_SOUTH = 1'b1
  } grant_e;

endpackage

// ==== hdl/vcache_decode.sv ====
//--------------------------------------------------
// one-entry request register
// claims requests for this row, forwards the rest
//--------------------------------------------------

`timescale 1ns/10ps

module vcache_decode (
  input  logic              clk_i
  , input  logic              rst_n_i
  , input  vcache_pkg::row_t  my_row_i

  , input  logic              req_v_i
  , input  logic              req_we_i
  , input  vcache_pkg::row_t  req_row_i
  , input  vcache_pkg::addr_t req_addr_i
  , input  vcache_pkg::data_t req_data_i
  , input  vcache_pkg::tag_t  req_tag_i
  , output logic              req_ready_o

  , output logic              loc_v_o
  , output logic              loc_we_o
  , output vcache_pkg::addr_t loc_addr_o
  , output vcache_pkg::data_t loc_data_o
  , output vcache_pkg::tag_t  loc_tag_o
  , input  logic              loc_ready_i

  , output logic              req_v_o
  , output logic              req_we_o
  , output vcache_pkg::row_t  req_row_o
  , output vcache_pkg::addr_t req_addr_o
  , output vcache_pkg::data_t req_data_o
  , output vcache_pkg::tag_t  req_tag_o
  , input  logic              req_ready_i
);
  import vcache_pkg::*;

  logic  full_r;
  logic  local_r;
  logic  we_r;
  row_t  row_r;
  addr_t addr_r;
  data_t data_r;
  tag_t  tag_r;
  logic  leave;
  logic  accept;

  // held entry drains toward the side it was marked for
  assign leave       = full_r & (local_r ? loc_ready_i : req_ready_i);
  assign req_ready_o = ~full_r | leave;
  assign accept      = req_v_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_r  <= 1'b0;
      local_r <= 1'b0;
    end else if (accept) begin
      full_r  <= 1'b1;
      local_r <= (req_row_i == my_row_i);
    end else if (leave) begin
      full_r  <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_r   <= req_we_i;
      row_r  <= req_row_i;
      addr_r <= req_addr_i;
      data_r <= req_data_i;
      tag_r  <= req_tag_i;
    end
  end

  assign loc_v_o    = full_r & local_r;
  assign loc_we_o   = we_r;
  assign loc_addr_o = addr_r;
  assign loc_data_o = data_r;
  assign loc_tag_o  = tag_r;

  // forwarded unchanged
  assign req_v_o    = full_r & ~local_r;
  assign req_we_o   = we_r;
  assign req_row_o  = row_r;
  assign req_addr_o = addr_r;
  assign req_data_o = data_r;
  assign req_tag_o  = tag_r;

endmodule

// ==== hdl/vcache_execute.sv ====
//--------------------------------------------------
// local word bank with load and store
// one-entry local response register
//--------------------------------------------------

`timescale 1ns/10ps

module vcache_execute #(
  parameter int bank_words_p = 16
) (
  input  logic              clk_i
  , input  logic              rst_n_i

  , input  logic              loc_v_i
  , input  logic              loc_we_i
  , input  vcache_pkg::addr_t loc_addr_i
  , input  vcache_pkg::data_t loc_data_i
  , input  vcache_pkg::tag_t  loc_tag_i
  , output logic              loc_ready_o

  , output logic              lrsp_v_o
  , output vcache_pkg::data_t lrsp_data_o
  , output vcache_pkg::tag_t  lrsp_tag_o
  , input  logic              lrsp_ready_i
);
  import vcache_pkg::*;

  localparam int idx_width_lp = (bank_words_p > 1) ? $clog2(bank_words_p) : 1;

  data_t                   bank_r [bank_words_p];
  logic [idx_width_lp-1:0] idx;
  logic                    accept;
  logic                    out_v_r;
  data_t                   out_data_r;
  tag_t                    out_tag_r;

  // low address bits pick the word
  assign idx = loc_addr_i[idx_width_lp-1:0];

  // take a new request when the reply slot is empty or leaving
  assign loc_ready_o = ~out_v_r | lrsp_ready_i;
  assign accept      = loc_v_i & loc_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_v_r <= 1'b0;
    end else if (accept) begin
      out_v_r <= 1'b1;
    end else if (lrsp_ready_i) begin
      out_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      out_tag_r <= loc_tag_i;
      if (loc_we_i) begin
        bank_r[idx] <= loc_data_i;
        // stores reply with zero
        out_data_r  <= '0;
      end else begin
        out_data_r  <= bank_r[idx];
      end
    end
  end

  assign lrsp_v_o    = out_v_r;
  assign lrsp_data_o = out_data_r;
  assign lrsp_tag_o  = out_tag_r;

endmodule

// ==== hdl/vcache_result.sv ====
//--------------------------------------------------
// round-robin merge of local and south responses
// registered onto the north response port
//--------------------------------------------------

`timescale 1ns/10ps

module vcache_result (
  input  logic              clk_i
  , input  logic              rst_n_i

  , input  logic              lrsp_v_i
  , input  vcache_pkg::data_t lrsp_data_i
  , input  vcache_pkg::tag_t  lrsp_tag_i
  , output logic              lrsp_ready_o

  , input  logic              rsp_v_i
  , input  vcache_pkg::data_t rsp_data_i
  , input  vcache_pkg::tag_t  rsp_tag_i
  , output logic              rsp_ready_o

  , output logic              rsp_v_o
  , output vcache_pkg::data_t rsp_data_o
  , output vcache_pkg::tag_t  rsp_tag_o
  , input  logic              rsp_ready_i
);
  import vcache_pkg::*;

  grant_e last_r;
  logic   out_v_r;
  data_t  out_data_r;
  tag_t   out_tag_r;
  logic   out_free;
  logic   local_take;
  logic   south_take;

  assign out_free = ~out_v_r | rsp_ready_i;

  // each side's ready looks only at the other side's valid
  // on a tie the side not granted last wins
  assign lrsp_ready_o = out_free & (~rsp_v_i | (last_r == GRANT_SOUTH));
  assign rsp_ready_o  = out_free & (~lrsp_v_i | (last_r == GRANT_LOCAL));

  assign local_take = lrsp_v_i & lrsp_ready_o;
  assign south_take = rsp_v_i & rsp_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_v_r <= 1'b0;
      last_r  <= GRANT_SOUTH;
    end else if (local_take) begin
      out_v_r <= 1'b1;
      last_r  <= GRANT_LOCAL;
    end else if (south_take) begin
      out_v_r <= 1'b1;
      last_r  <= GRANT_SOUTH;
    end else if (rsp_ready_i) begin
      out_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (local_take) begin
      out_data_r <= lrsp_data_i;
      out_tag_r  <= lrsp_tag_i;
    end else if (south_take) begin
      out_data_r <= rsp_data_i;
      out_tag_r  <= rsp_tag_i;
    end
  end

  assign rsp_v_o    = out_v_r;
  assign rsp_data_o = out_data_r;
  assign rsp_tag_o  = out_tag_r;

endmodule

// ==== hdl/vcache_tile.sv ====
//--------------------------------------------------
// one memory-bank tile of a column
// reset and row registers, decode/execute/result
//--------------------------------------------------

`timescale 1ns/10ps

module vcache_tile #(
  parameter int bank_words_p = 16
) (
  input  logic              clk_i
  , input  logic              rst_n_i
  , output logic              rst_n_o
  , input  vcache_pkg::row_t  global_y_i
  , output vcache_pkg::row_t  global_y_o

  // north request in
  , input  logic              req_v_i
  , input  logic              req_we_i
  , input  vcache_pkg::row_t  req_row_i
  , input  vcache_pkg::addr_t req_addr_i
  , input  vcache_pkg::data_t req_data_i
  , input  vcache_pkg::tag_t  req_tag_i
  , output logic              req_ready_o

  // south request out
  , output logic              req_v_o
  , output logic              req_we_o
  , output vcache_pkg::row_t  req_row_o
  , output vcache_pkg::addr_t req_addr_o
  , output vcache_pkg::data_t req_data_o
  , output vcache_pkg::tag_t  req_tag_o
  , input  logic              req_ready_i

  // south response in
  , input  logic              rsp_v_i
  , input  vcache_pkg::data_t rsp_data_i
  , input  vcache_pkg::tag_t  rsp_tag_i
  , output logic              rsp_ready_o

  // north response out
  , output logic              rsp_v_o
  , output vcache_pkg::data_t rsp_data_o
  , output vcache_pkg::tag_t  rsp_tag_o
  , input  logic              rsp_ready_i
);
  import vcache_pkg::*;

  logic  rst_n_r;
  row_t  y_r;

  logic  loc_v;
  logic  loc_we;
  addr_t loc_addr;
  data_t loc_data;
  tag_t  loc_tag;
  logic  loc_ready;

  logic  lrsp_v;
  data_t lrsp_data;
  tag_t  lrsp_tag;
  logic  lrsp_ready;

  // reset and coordinate pipeline down the column
  always_ff @(posedge clk_i) begin
    rst_n_r <= rst_n_i;
    y_r     <= global_y_i;
  end

  assign rst_n_o    = rst_n_r;
  assign global_y_o = y_r + row_t'(1);

  vcache_decode u_decode (
    .clk_i        (clk_i)
    ,.rst_n_i     (rst_n_r)
    ,.my_row_i    (y_r)
    ,.req_v_i     (req_v_i)
    ,.req_we_i    (req_we_i)
    ,.req_row_i   (req_row_i)
    ,.req_addr_i  (req_addr_i)
    ,.req_data_i  (req_data_i)
    ,.req_tag_i   (req_tag_i)
    ,.req_ready_o (req_ready_o)
    ,.loc_v_o     (loc_v)
    ,.loc_we_o    (loc_we)
    ,.loc_addr_o  (loc_addr)
    ,.loc_data_o  (loc_data)
    ,.loc_tag_o   (loc_tag)
    ,.loc_ready_i (loc_ready)
    ,.req_v_o     (req_v_o)
    ,.req_we_o    (req_we_o)
    ,.req_row_o   (req_row_o)
    ,.req_addr_o  (req_addr_o)
    ,.req_data_o  (req_data_o)
    ,.req_tag_o   (req_tag_o)
    ,.req_ready_i (req_ready_i)
  );

  vcache_execute #(
    .bank_words_p(bank_words_p)
  ) u_execute (
    .clk_i         (clk_i)
    ,.rst_n_i      (rst_n_r)
    ,.loc_v_i      (loc_v)
    ,.loc_we_i     (loc_we)
    ,.loc_addr_i   (loc_addr)
    ,.loc_data_i   (loc_data)
    ,.loc_tag_i    (loc_tag)
    ,.loc_ready_o  (loc_ready)
    ,.lrsp_v_o     (lrsp_v)
    ,.lrsp_data_o  (lrsp_data)
    ,.lrsp_tag_o   (lrsp_tag)
    ,.lrsp_ready_i (lrsp_ready)
  );

  vcache_result u_result (
    .clk_i         (clk_i)
    ,.rst_n_i      (rst_n_r)
    ,.lrsp_v_i     (lrsp_v)
    ,.lrsp_data_i  (lrsp_data)
    ,.lrsp_tag_i   (lrsp_tag)
    ,.lrsp_ready_o (lrsp_ready)
    ,.rsp_v_i      (rsp_v_i)
    ,.rsp_data_i   (rsp_data_i)
    ,.rsp_tag_i    (rsp_tag_i)
    ,.rsp_ready_o  (rsp_ready_o)
    ,.rsp_v_o      (rsp_v_o)
    ,.rsp_data_o   (rsp_data_o)
    ,.rsp_tag_o    (rsp_tag_o)
    ,.rsp_ready_i  (rsp_ready_i)
  );

endmodule

// ==== hdl/vcache_tile_array.sv ====
//--------------------------------------------------
// rows by columns grid of vcache tiles
// each column chained north to south
//--------------------------------------------------

`timescale 1ns/10ps

module vcache_tile_array #(
  parameter int num_rows_p     = 2
  , parameter int num_cols_p   = 2
  , parameter int bank_words_p = 16
) (
  input  logic                                clk_i
  , input  logic             [num_cols_p-1:0] rst_n_i
  , output logic             [num_cols_p-1:0] rst_n_o
  , input  vcache_pkg::row_t [num_cols_p-1:0] global_y_i
  , output vcache_pkg::row_t [num_cols_p-1:0] global_y_o

  // north request in
  , input  logic              [num_cols_p-1:0] req_v_i
  , input  logic              [num_cols_p-1:0] req_we_i
  , input  vcache_pkg::row_t  [num_cols_p-1:0] req_row_i
  , input  vcache_pkg::addr_t [num_cols_p-1:0] req_addr_i
  , input  vcache_pkg::data_t [num_cols_p-1:0] req_data_i
  , input  vcache_pkg::tag_t  [num_cols_p-1:0] req_tag_i
  , output logic              [num_cols_p-1:0] req_ready_o

  // north response out
  , output logic              [num_cols_p-1:0] rsp_v_o
  , output vcache_pkg::data_t [num_cols_p-1:0] rsp_data_o
  , output vcache_pkg::tag_t  [num_cols_p-1:0] rsp_tag_o
  , input  logic              [num_cols_p-1:0] rsp_ready_i

  // south request out, toward external memory
  , output logic              [num_cols_p-1:0] req_v_o
  , output logic              [num_cols_p-1:0] req_we_o
  , output vcache_pkg::row_t  [num_cols_p-1:0] req_row_o
  , output vcache_pkg::addr_t [num_cols_p-1:0] req_addr_o
  , output vcache_pkg::data_t [num_cols_p-1:0] req_data_o
  , output vcache_pkg::tag_t  [num_cols_p-1:0] req_tag_o
  , input  logic              [num_cols_p-1:0] req_ready_i

  // south response in
  , input  logic              [num_cols_p-1:0] rsp_v_i
  , input  vcache_pkg::data_t [num_cols_p-1:0] rsp_data_i
  , input  vcache_pkg::tag_t  [num_cols_p-1:0] rsp_tag_i
  , output logic              [num_cols_p-1:0] rsp_ready_o
);
  import vcache_pkg::*;

  // index 0 is the north edge, num_rows_p the south edge
  logic  rst_n_w     [num_rows_p+1][num_cols_p];
  row_t  y_w         [num_rows_p+1][num_cols_p];
  logic  req_v_w     [num_rows_p+1][num_cols_p];
  logic  req_we_w    [num_rows_p+1][num_cols_p];
  row_t  req_row_w   [num_rows_p+1][num_cols_p];
  addr_t req_addr_w  [num_rows_p+1][num_cols_p];
  data_t req_data_w  [num_rows_p+1][num_cols_p];
  tag_t  req_tag_w   [num_rows_p+1][num_cols_p];
  logic  req_ready_w [num_rows_p+1][num_cols_p];
  logic  rsp_v_w     [num_rows_p+1][num_cols_p];
  data_t rsp_data_w  [num_rows_p+1][num_cols_p];
  tag_t  rsp_tag_w   [num_rows_p+1][num_cols_p];
  logic  rsp_ready_w [num_rows_p+1][num_cols_p];

  for (genvar x = 0; x < num_cols_p; x++) begin : col_g
    // north edge
    assign rst_n_w[0][x]     = rst_n_i[x];
    assign y_w[0][x]         = global_y_i[x];
    assign req_v_w[0][x]     = req_v_i[x];
    assign req_we_w[0][x]    = req_we_i[x];
    assign req_row_w[0][x]   = req_row_i[x];
    assign req_addr_w[0][x]  = req_addr_i[x];
    assign req_data_w[0][x]  = req_data_i[x];
    assign req_tag_w[0][x]   = req_tag_i[x];
    assign req_ready_o[x]    = req_ready_w[0][x];
    assign rsp_v_o[x]        = rsp_v_w[0][x];
    assign rsp_data_o[x]     = rsp_data_w[0][x];
    assign rsp_tag_o[x]      = rsp_tag_w[0][x];
    assign rsp_ready_w[0][x] = rsp_ready_i[x];

    // south edge
    assign rst_n_o[x]                 = rst_n_w[num_rows_p][x];
    assign global_y_o[x]              = y_w[num_rows_p][x];
    assign req_v_o[x]                 = req_v_w[num_rows_p][x];
    assign req_we_o[x]                = req_we_w[num_rows_p][x];
    assign req_row_o[x]               = req_row_w[num_rows_p][x];
    assign req_addr_o[x]              = req_addr_w[num_rows_p][x];
    assign req_data_o[x]              = req_data_w[num_rows_p][x];
    assign req_tag_o[x]               = req_tag_w[num_rows_p][x];
    assign req_ready_w[num_rows_p][x] = req_ready_i[x];
    assign rsp_v_w[num_rows_p][x]     = rsp_v_i[x];
    assign rsp_data_w[num_rows_p][x]  = rsp_data_i[x];
    assign rsp_tag_w[num_rows_p][x]   = rsp_tag_i[x];
    assign rsp_ready_o[x]             = rsp_ready_w[num_rows_p][x];

    for (genvar y = 0; y < num_rows_p; y++) begin : row_g
      vcache_tile #(
        .bank_words_p(bank_words_p)
      ) u_tile (
        .clk_i        (clk_i)
        ,.rst_n_i     (rst_n_w[y][x])
        ,.rst_n_o     (rst_n_w[y+1][x])
        ,.global_y_i  (y_w[y][x])
        ,.global_y_o  (y_w[y+1][x])
        ,.req_v_i     (req_v_w[y][x])
        ,.req_we_i    (req_we_w[y][x])
        ,.req_row_i   (req_row_w[y][x])
        ,.req_addr_i  (req_addr_w[y][x])
        ,.req_data_i  (req_data_w[y][x])
        ,.req_tag_i   (req_tag_w[y][x])
        ,.req_ready_o (req_ready_w[y][x])
        ,.req_v_o     (req_v_w[y+1][x])
        ,.req_we_o    (req_we_w[y+1][x])
        ,.req_row_o   (req_row_w[y+1][x])
        ,.req_addr_o  (req_addr_w[y+1][x])
        ,.req_data_o  (req_data_w[y+1][x])
        ,.req_tag_o   (req_tag_w[y+1][x])
        ,.req_ready_i (req_ready_w[y+1][x])
        ,.rsp_v_i     (rsp_v_w[y+1][x])
        ,.rsp_data_i  (rsp_data_w[y+1][x])
        ,.rsp_tag_i   (rsp_tag_w[y+1][x])
        ,.rsp_ready_o (rsp_ready_w[y+1][x])
        ,.rsp_v_o     (rsp_v_w[y][x])
        ,.rsp_data_o  (rsp_data_w[y][x])
        ,.rsp_tag_o   (rsp_tag_w[y][x])
        ,.rsp_ready_i (rsp_ready_w[y][x])
      );
    end
  end

endmodule

// ==== tb/tb_vcache_tile_array.sv ====
//--------------------------------------------------
// testbench for the vcache tile array
// clock, stimulus, south memory model, checks
//--------------------------------------------------

`timescale 1ns/10ps

module tb_vcache_tile_array;
  import vcache_pkg::*;

  localparam int num_rows_p   = 2;
  localparam int num_cols_p   = 2;
  localparam int bank_words_p = 16;
  localparam int dir_count    = 2 * num_rows_p * bank_words_p + 10;
  localparam int req_per_col  = dir_count + 60;
  localparam int cycle_limit  = 40 * num_cols_p * req_per_col + 200;

  logic                    clk;
  logic  [num_cols_p-1:0]  rst_n;
  logic  [num_cols_p-1:0]  rst_n_o;
  row_t  [num_cols_p-1:0]  global_y_i;
  row_t  [num_cols_p-1:0]  global_y_o;
  logic  [num_cols_p-1:0]  req_v;
  logic  [num_cols_p-1:0]  req_we;
  row_t  [num_cols_p-1:0]  req_row;
  addr_t [num_cols_p-1:0]  req_addr;
  data_t [num_cols_p-1:0]  req_data;
  tag_t  [num_cols_p-1:0]  req_tag;
  logic  [num_cols_p-1:0]  req_ready;
  logic  [num_cols_p-1:0]  rsp_v;
  data_t [num_cols_p-1:0]  rsp_data;
  tag_t  [num_cols_p-1:0]  rsp_tag;
  logic  [num_cols_p-1:0]  rsp_ready;
  logic  [num_cols_p-1:0]  s_req_v;
  logic  [num_cols_p-1:0]  s_req_we;
  row_t  [num_cols_p-1:0]  s_req_row;
  addr_t [num_cols_p-1:0]  s_req_addr;
  data_t [num_cols_p-1:0]  s_req_data;
  tag_t  [num_cols_p-1:0]  s_req_tag;
  logic  [num_cols_p-1:0]  s_req_ready;
  logic  [num_cols_p-1:0]  s_rsp_v;
  data_t [num_cols_p-1:0]  s_rsp_data;
  tag_t  [num_cols_p-1:0]  s_rsp_tag;
  logic  [num_cols_p-1:0]  s_rsp_ready;

  int    seed = 78095;
  int    value_errors = 0;
  int    other_errors = 0;
  bit    timed_out;
  // request lists per column, in issue order
  bit    rq_we      [num_cols_p][req_per_col];
  int    rq_row     [num_cols_p][req_per_col];
  int    rq_addr    [num_cols_p][req_per_col];
  data_t rq_data    [num_cols_p][req_per_col];
  int    next_idx   [num_cols_p];
  int    returned   [num_cols_p];
  // request in flight per tag
  int    issue_seq  [num_cols_p][64];
  int    return_seq [num_cols_p][64];
  bit    iss_we     [num_cols_p][64];
  int    iss_row    [num_cols_p][64];
  int    iss_addr   [num_cols_p][64];
  data_t iss_data   [num_cols_p][64];
  data_t exp_data   [num_cols_p][64];
  data_t ref_bank   [num_cols_p][num_rows_p][bank_words_p];
  data_t ref_south  [int];
  // south memory and its reply queue
  data_t south_mem  [int];
  data_t mq_data    [num_cols_p][64];
  tag_t  mq_tag     [num_cols_p][64];
  int    mq_head    [num_cols_p];
  int    mq_tail    [num_cols_p];
  int    mq_count   [num_cols_p];
  int    mem_wait   [num_cols_p];
  bit    req_fire   [num_cols_p];
  bit    srsp_fire  [num_cols_p];

  vcache_tile_array #(
    .num_rows_p    (num_rows_p)
    ,.num_cols_p   (num_cols_p)
    ,.bank_words_p (bank_words_p)
  ) u_vcache_tile_array (
    .clk_i        (clk)
    ,.rst_n_i     (rst_n)
    ,.rst_n_o     (rst_n_o)
    ,.global_y_i  (global_y_i)
    ,.global_y_o  (global_y_o)
    ,.req_v_i     (req_v)
    ,.req_we_i    (req_we)
    ,.req_row_i   (req_row)
    ,.req_addr_i  (req_addr)
    ,.req_data_i  (req_data)
    ,.req_tag_i   (req_tag)
    ,.req_ready_o (req_ready)
    ,.rsp_v_o     (rsp_v)
    ,.rsp_data_o  (rsp_data)
    ,.rsp_tag_o   (rsp_tag)
    ,.rsp_ready_i (rsp_ready)
    ,.req_v_o     (s_req_v)
    ,.req_we_o    (s_req_we)
    ,.req_row_o   (s_req_row)
    ,.req_addr_o  (s_req_addr)
    ,.req_data_o  (s_req_data)
    ,.req_tag_o   (s_req_tag)
    ,.req_ready_i (s_req_ready)
    ,.rsp_v_i     (s_rsp_v)
    ,.rsp_data_i  (s_rsp_data)
    ,.rsp_tag_i   (s_rsp_tag)
    ,.rsp_ready_o (s_rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  // untouched south words read back a pattern of their full address
  function automatic data_t fill_word(input int key);
    return data_t'(key) ^ 32'h5a5a_0000;
  endfunction

  // reference model, applied in issue order per column
  function automatic data_t expected_data(input int c, input bit we, input int row,
                                          input int addr, input data_t data);
    int    key;
    data_t res;
    key = c * 4096 + row * 256 + addr;
    res = '0;
    if (row < num_rows_p) begin
      if (we) ref_bank[c][row][addr] = data;
      else res = ref_bank[c][row][addr];
    end else begin
      if (we) ref_south[key] = data;
      else if (ref_south.exists(key)) res = ref_south[key];
      else res = fill_word(key);
    end
    return res;
  endfunction

  task automatic set_request(input int c, input int n, input int we, input int row,
                             input int addr);
    rq_we[c][n]   = (we != 0);
    rq_row[c][n]  = row;
    rq_addr[c][n] = addr;
    rq_data[c][n] = $random(seed);
  endtask

  task automatic build_stimulus;
    int n;
    int r;
    int row;
    for (int c = 0; c < num_cols_p; c++) begin
      n = 0;
      // every word of every tile stored, then loaded back
      for (int we = 1; we >= 0; we--) begin
        for (int y = 0; y < num_rows_p; y++) begin
          for (int a = 0; a < bank_words_p; a++) begin
            set_request(c, n, we, y, a);
            n++;
          end
        end
      end
      for (int k = 0; k < 8; k++) begin
        set_request(c, n, (k < 4) ? 1 : 0, num_rows_p + (k & 1), (k & 3) * 3);
        n++;
      end
      // south words never written
      for (int k = 0; k < 2; k++) begin
        set_request(c, n, 0, num_rows_p + 1, 200 + k);
        n++;
      end
      while (n < req_per_col) begin
        r   = $random(seed) & 32'h7fff_ffff;
        row = r % (num_rows_p + 2);
        set_request(c, n, (r >> 20) & 1, row,
                    (r >> 8) % ((row < num_rows_p) ? bank_words_p : 256));
        n++;
      end
    end
  endtask

  task automatic serve_south_request(input int c);
    int    key;
    data_t d;
    key = c * 4096 + int'(s_req_row[c]) * 256 + int'(s_req_addr[c]);
    if (s_req_we[c]) begin
      south_mem[key] = s_req_data[c];
      d = '0;
    end else if (south_mem.exists(key)) begin
      d = south_mem[key];
    end else begin
      d = fill_word(key);
    end
    mq_data[c][mq_tail[c]] = d;
    mq_tag[c][mq_tail[c]]  = s_req_tag[c];
    mq_tail[c] = (mq_tail[c] + 1) % 64;
    if (mq_count[c] == 0) mem_wait[c] = 1 + ($random(seed) & 3);
    mq_count[c]++;
  endtask

  task automatic sample_handshakes;
    for (int c = 0; c < num_cols_p; c++) begin
      req_fire[c]  = (req_v[c] && req_ready[c]);
      srsp_fire[c] = (s_rsp_v[c] && s_rsp_ready[c]);
      if (s_req_v[c] && s_req_ready[c]) serve_south_request(c);
    end
  endtask

  task automatic drive_column(input int c);
    int i;
    int t;
    bit stress;
    if (req_fire[c]) begin
      i = next_idx[c];
      t = i % 64;
      iss_we[c][t]   = rq_we[c][i];
      iss_row[c][t]  = rq_row[c][i];
      iss_addr[c][t] = rq_addr[c][i];
      iss_data[c][t] = rq_data[c][i];
      exp_data[c][t] = expected_data(c, rq_we[c][i], rq_row[c][i], rq_addr[c][i],
                                     rq_data[c][i]);
      issue_seq[c][t]++;
      next_idx[c]++;
      req_v[c] = 1'b0;
    end
    t = next_idx[c] % 64;
    // a tag is reused only once its last response is back
    if (!req_v[c] && next_idx[c] < req_per_col && issue_seq[c][t] == return_seq[c][t]) begin
      i = next_idx[c];
      req_v[c]    = 1'b1;
      req_we[c]   = rq_we[c][i];
      req_row[c]  = row_t'(rq_row[c][i]);
      req_addr[c] = addr_t'(rq_addr[c][i]);
      req_data[c] = rq_data[c][i];
      req_tag[c]  = tag_t'(t);
    end
    // random back-pressure after the directed part
    stress = (next_idx[c] >= dir_count);
    rsp_ready[c]   = stress ? (($random(seed) & 3) != 0) : 1'b1;
    s_req_ready[c] = stress ? (($random(seed) & 1) != 0) : 1'b1;
    if (srsp_fire[c]) begin
      s_rsp_v[c]  = 1'b0;
      mq_head[c]  = (mq_head[c] + 1) % 64;
      mq_count[c]--;
      mem_wait[c] = 1 + ($random(seed) & 3);
    end
    if (!s_rsp_v[c] && mq_count[c] > 0) begin
      if (mem_wait[c] > 0) begin
        mem_wait[c]--;
      end else begin
        s_rsp_v[c]    = 1'b1;
        s_rsp_data[c] = mq_data[c][mq_head[c]];
        s_rsp_tag[c]  = mq_tag[c][mq_head[c]];
      end
    end
  endtask

  function automatic bit all_done;
    bit done;
    done = 1'b1;
    for (int c = 0; c < num_cols_p; c++) begin
      if (next_idx[c] != req_per_col || returned[c] != req_per_col) done = 1'b0;
    end
    return done;
  endfunction

  initial begin
    int cycles;
    rst_n       = '0;
    global_y_i  = '0;
    req_v       = '0;
    req_we      = '0;
    req_row     = '0;
    req_addr    = '0;
    req_data    = '0;
    req_tag     = '0;
    rsp_ready   = '0;
    s_req_ready = '0;
    s_rsp_v     = '0;
    s_rsp_data  = '0;
    s_rsp_tag   = '0;
    timed_out   = 1'b0;
    cycles      = 0;
    build_stimulus();
    repeat (8) @(posedge clk);
    #2;
    rst_n = '1;
    // reset has to ripple down every row first
    repeat (num_rows_p + 2) @(posedge clk);
    while (!all_done() && !timed_out) begin
      @(negedge clk);
      sample_handshakes();
      @(posedge clk);
      #2;
      for (int c = 0; c < num_cols_p; c++) drive_column(c);
      cycles++;
      if (cycles > cycle_limit) begin
        $display("timeout: %0d cycles passed with requests still outstanding", cycles);
        timed_out = 1'b1;
      end
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errors,
             other_errors + int'(timed_out));
    if (value_errors == 0 && other_errors == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // response checker, sampled at the falling edge
  initial begin
    int t;
    wait (rst_n[0] === 1'b1);
    for (int i = 1; i <= num_rows_p; i++) begin
      @(posedge clk);
      @(negedge clk);
      for (int c = 0; c < num_cols_p; c++) begin
        check_value($sformatf("rst_n_o[%0d]", c), 32'(rst_n_o[c]), 32'(i == num_rows_p));
      end
    end
    for (int c = 0; c < num_cols_p; c++) begin
      check_value($sformatf("rsp_v_o[%0d]", c), 32'(rsp_v[c]), 32'h0);
      check_value($sformatf("req_v_o[%0d]", c), 32'(s_req_v[c]), 32'h0);
      check_value($sformatf("global_y_o[%0d]", c), 32'(global_y_o[c]),
                  32'(global_y_i[c]) + 32'(num_rows_p));
    end
    forever begin
      @(negedge clk);
      for (int c = 0; c < num_cols_p; c++) begin
        if (rsp_v[c] && rsp_ready[c]) begin
          t = int'(rsp_tag[c]);
          if (issue_seq[c][t] == return_seq[c][t]) begin
            $display("column %0d returned tag %0d at %0d ns with no request outstanding",
                     c, t, $time);
            other_errors++;
          end else begin
            check_value($sformatf("rsp_data_o[%0d] tag %0d", c, t), rsp_data[c],
                        exp_data[c][t]);
            return_seq[c][t]++;
            returned[c]++;
          end
        end
        if (s_req_v[c] && s_req_ready[c]) begin
          t = int'(s_req_tag[c]);
          if (issue_seq[c][t] == return_seq[c][t] || iss_row[c][t] < num_rows_p) begin
            $display("column %0d sent tag %0d south at %0d ns but it is no south request",
                     c, t, $time);
            other_errors++;
          end else begin
            check_value($sformatf("req_row_o[%0d]", c), 32'(s_req_row[c]), iss_row[c][t]);
            check_value($sformatf("req_we_o[%0d]", c), 32'(s_req_we[c]), 32'(iss_we[c][t]));
            check_value($sformatf("req_addr_o[%0d]", c), 32'(s_req_addr[c]), iss_addr[c][t]);
            check_value($sformatf("req_data_o[%0d]", c), s_req_data[c], iss_data[c][t]);
          end
        end
      end
    end
  end

endmodule

// ==== sources.f ====
hdl/vcache_pkg.sv
hdl/vcache_decode.sv
hdl/vcache_execute.sv
hdl/vcache_result.sv
hdl/vcache_tile.sv
hdl/vcache_tile_array.sv
tb/tb_vcache_tile_array.sv

// ==== run.sh ====
#!/bin/sh
# build and run the vcache tile array testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_vcache_tile_array \
  -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '** FAIL **' sim.log; then
  exit 1
fi
exit 0
